// ==== Makefile ====
SIM      := verilator
TOP      := convEngineTb
FILELIST := flist.f
FLAGS    := --binary --assert --timing --timescale 1ns/10ps -j 0 --top-module $(TOP)
RUNFLAGS := +verilator+error+limit+1000
BUILD    := obj_dir
LOG      := sim.log
FAIL_MSG := Errors found

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) -f $(FILELIST) --Mdir $(BUILD)
	@./$(BUILD)/V$(TOP) $(RUNFLAGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation FAILED"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

// ==== flist.f ====
+incdir+verilog
verilog/convPkg.sv
verilog/frameControl.sv
verilog/rowWindowBuffer.sv
verilog/convMacTree.sv
verilog/convEngine.sv
tb/convEngine_assert.sv
tb/convEngineTb.sv

// ==== tb/convEngineTb.sv ====
`timescale 1ns/10ps
`include "conv_settings.svh"

module convEngineTb import convPkg::*; ();

	localparam int PIX = `CONV_PIXEL_BITS;
	// Heights of the frame tests set the watchdog limit
	localparam int TEST_ROWS = 5 + 8 + 6 + 3;
	localparam int WATCHDOG_CYCLES = 400 * TEST_ROWS + 100;

	logic    clk;
	logic    reset;
	logic    startPulse;
	rowIdxT  heightIn;
	rowWordT rowData;
	logic    rowValid;
	logic    rowReady;
	resultT  result;
	logic    resultValid;
	logic    resultReady;
	logic    busy;

	int      seed;
	logic    randomReady;
	rowWordT sentRows [$];
	int      rcvRow;
	int      rcvCol;
	int      rcvCount;
	int      expTotal;
	int      errCount;
	int      checkCount;
	int      testCount;
	int      totalErr;

	convEngine DUT (
		.clk           (clk),
		.reset         (reset),
		.i_start       (startPulse),
		.i_height      (heightIn),
		.i_rowData     (rowData),
		.i_rowValid    (rowValid),
		.o_rowReady    (rowReady),
		.o_result      (result),
		.o_resultValid (resultValid),
		.i_resultReady (resultReady),
		.o_busy        (busy)
	);

	bind convEngine convEngineAssert uAssert (
		.clk           (clk),
		.reset         (reset),
		.i_start       (i_start),
		.i_height      (i_height),
		.i_rowReady    (o_rowReady),
		.i_result      (o_result),
		.i_resultValid (o_resultValid),
		.i_resultReady (i_resultReady),
		.i_busy        (o_busy)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Pixel k of a sent row
	function automatic int pixelAt(input int r, input int k);
		return int'(sentRows[r][k*PIX +: PIX]);
	endfunction

	// Sharpening sum over rows r..r+2 and columns c..c+2
	function automatic sumT expectedSum(input int r, input int c);
		int centre;
		int neighbours;
		centre = pixelAt(r + 1, c + 1);
		neighbours = 0;
		for (int dr = 0; dr < 3; dr++) begin
			for (int dc = 0; dc < 3; dc++) begin
				neighbours += pixelAt(r + dr, c + dc);
			end
		end
		neighbours -= centre;
		return sumT'(9 * centre - neighbours);
	endfunction

	task automatic checkResult();
		resultT expResult;
		expResult.sum           = expectedSum(rcvRow, rcvCol);
		expResult.tag.outRow    = rowIdxT'(rcvRow);
		expResult.tag.outCol    = colIdxT'(rcvCol);
		expResult.tag.lastPixel = (rcvCount == expTotal - 1);
		checkCount++;
		assert (rcvCount < expTotal) else begin
			$display("Extra result at time %0t beyond the %0d expected", $time, expTotal);
			errCount++;
		end
		assert (result == expResult) else begin
			$display("FAIL %0t: row %0d col %0d got sum %0d tag %h, expected sum %0d tag %h",
				$time, rcvRow, rcvCol, result.sum, result.tag, expResult.sum, expResult.tag);
			errCount++;
		end
		rcvCount++;
		if (rcvCol == `CONV_OUT_COLS - 1) begin
			rcvCol = 0;
			rcvRow++;
		end else begin
			rcvCol++;
		end
	endtask

	// Transfers sampled at the edge where they happen
	always @(posedge clk) begin
		if (!reset && resultValid && resultReady) begin
			checkResult();
		end
	end

	// Sink ready is random only in the back-pressure test
	always @(negedge clk) begin
		if (randomReady) begin
			resultReady = $random(seed) & 1;
		end else begin
			resultReady = 1'b1;
		end
	end

	task automatic runFrame(input string name, input int rows, input bit randomPix,
		input bit stallOut);
		rowWordT data;
		int startErr;
		sentRows.delete();
		rcvRow   = 0;
		rcvCol   = 0;
		rcvCount = 0;
		expTotal = `CONV_OUT_COLS * (rows - 2);
		startErr = errCount;
		randomReady = stallOut;
		@(negedge clk);
		startPulse = 1'b1;
		heightIn   = rowIdxT'(rows);
		@(negedge clk);
		startPulse = 1'b0;
		for (int i = 0; i < rows; i++) begin
			if (randomPix) begin
				for (int w = 0; w < 8; w++) begin
					data[w*32 +: 32] = $random(seed);
				end
			end else begin
				data = {`CONV_ROW_PIXELS{pixelT'(100)}};
			end
			sentRows.push_back(data);
			rowData  = data;
			rowValid = 1'b1;
			@(posedge clk);
			while (!rowReady) @(posedge clk);
			@(negedge clk);
			rowValid = 1'b0;
		end
		// Frame ends when every result is out and the sequencer is idle
		while ((rcvCount < expTotal) || busy) @(negedge clk);
		randomReady = 1'b0;
		repeat (4) @(negedge clk);
		testCount++;
		$display("Test %s finished: %0d of %0d results, %0d errors",
			name, rcvCount, expTotal, errCount - startErr);
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Errors found");
		$finish;
	end

	initial begin
		seed        = 32'ha976;
		reset       = 1'b1;
		startPulse  = 1'b0;
		heightIn    = '0;
		rowData     = '0;
		rowValid    = 1'b0;
		resultReady = 1'b1;
		randomReady = 1'b0;
		rcvRow      = 0;
		rcvCol      = 0;
		rcvCount    = 0;
		expTotal    = 0;
		errCount    = 0;
		checkCount  = 0;
		testCount   = 0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// Outputs must stay quiet with no start
		repeat (10) @(negedge clk);
		testCount++;
		$display("Test idle finished: 10 cycles without a start");

		runFrame("uniform", 5, 1'b0, 1'b0);
		runFrame("random", 8, 1'b1, 1'b0);
		runFrame("backpressure", 6, 1'b1, 1'b1);
		runFrame("restart", 3, 1'b1, 1'b0);

		totalErr = errCount + int'(DUT.uAssert.failCount);
		$display("Tests: %0d, results checked: %0d, errors: %0d",
			testCount, checkCount, totalErr);
		if (totalErr == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

// ==== tb/convEngine_assert.sv ====
`timescale 1ns/10ps
`include "conv_settings.svh"

module convEngineAssert import convPkg::*; (
	input logic   clk,
	input logic   reset,
	input logic   i_start,
	input rowIdxT i_height,
	input logic   i_rowReady,
	input resultT i_result,
	input logic   i_resultValid,
	input logic   i_resultReady,
	input logic   i_busy
);

	int unsigned failCount = 0;

	logic   seenStart;
	rowIdxT frameHeight;
	rowIdxT expRow;
	colIdxT expCol;
	int     xferCount;
	int     expTotal;
	logic   xfer;

	assign xfer     = i_resultValid && i_resultReady;
	assign expTotal = `CONV_OUT_COLS * (int'(frameHeight) - 2);

	// Raster position of the next result to leave the DUT
	always_ff @(posedge clk) begin
		if (reset) begin
			seenStart   <= 1'b0;
			frameHeight <= '0;
			expRow      <= '0;
			expCol      <= '0;
			xferCount   <= 0;
		end else if (i_start && !i_busy) begin
			seenStart   <= 1'b1;
			frameHeight <= i_height;
			expRow      <= '0;
			expCol      <= '0;
			xferCount   <= 0;
		end else if (xfer) begin
			xferCount <= xferCount + 1;
			if (expCol == colIdxT'(`CONV_OUT_COLS - 1)) begin
				expCol <= '0;
				expRow <= expRow + rowIdxT'(1);
			end else begin
				expCol <= expCol + colIdxT'(1);
			end
		end
	end

	quietBeforeStart: assert property (@(posedge clk) disable iff (reset)
		!seenStart |-> !i_rowReady && !i_resultValid && !i_busy)
		else begin
			$error("Outputs active before the first start");
			failCount++;
		end

	// Start moves the sequencer to LOAD on the next cycle
	startToLoad: assert property (@(posedge clk) disable iff (reset)
		i_start && !i_busy |=> i_busy && i_rowReady)
		else begin
			$error("Row input not ready one cycle after start");
			failCount++;
		end

	holdWhileStalled: assert property (@(posedge clk) disable iff (reset)
		i_resultValid && !i_resultReady |=> i_resultValid && $stable(i_result))
		else begin
			$error("Result changed or dropped while stalled");
			failCount++;
		end

	rasterOrder: assert property (@(posedge clk) disable iff (reset)
		xfer |-> (i_result.tag.outRow == expRow) && (i_result.tag.outCol == expCol))
		else begin
			$error("Result tag out of raster order");
			failCount++;
		end

	lastOnFinal: assert property (@(posedge clk) disable iff (reset)
		xfer |-> i_result.tag.lastPixel == (xferCount == expTotal - 1))
		else begin
			$error("Last pixel flag on the wrong result");
			failCount++;
		end

	noExtraResult: assert property (@(posedge clk) disable iff (reset)
		xfer |-> xferCount < expTotal)
		else begin
			$error("More results than the frame height allows");
			failCount++;
		end

endmodule

// ==== verilog/convEngine.sv ====
`timescale 1ns/10ps

module convEngine import convPkg::*; (
	input  logic    clk,
	input  logic    reset,
	input  logic    i_start,
	input  rowIdxT  i_height,
	input  rowWordT i_rowData,
	input  logic    i_rowValid,
	output logic    o_rowReady,
	output resultT  o_result,
	output logic    o_resultValid,
	input  logic    i_resultReady,
	output logic    o_busy
);

	logic   rowPush;
	logic   colRotate;
	logic   winValid;
	tagT    winTag;
	windowT window;

	// Sequencer for rows, sweep and realignment
	frameControl uFrameControl (
		.clk         (clk),
		.reset       (reset),
		.i_start     (i_start),
		.i_height    (i_height),
		.i_rowValid  (i_rowValid),
		.o_rowReady  (o_rowReady),
		.i_advance   (i_resultReady),
		.o_rowPush   (rowPush),
		.o_colRotate (colRotate),
		.o_winValid  (winValid),
		.o_winTag    (winTag),
		.o_busy      (o_busy)
	);

	rowWindowBuffer uRowWindowBuffer (
		.clk         (clk),
		.reset       (reset),
		.i_rowData   (i_rowData),
		.i_rowPush   (rowPush),
		.i_colRotate (colRotate),
		.o_window    (window)
	);

	// Sink ready stalls the whole tree
	convMacTree uConvMacTree (
		.clk           (clk),
		.reset         (reset),
		.i_advance     (i_resultReady),
		.i_window      (window),
		.i_winValid    (winValid),
		.i_winTag      (winTag),
		.o_result      (o_result),
		.o_resultValid (o_resultValid)
	);

endmodule

// ==== verilog/convMacTree.sv ====
`timescale 1ns/10ps
`include "conv_settings.svh"

module convMacTree import convPkg::*; (
	input  logic   clk,
	input  logic   reset,
	input  logic   i_advance,
	input  windowT i_window,
	input  logic   i_winValid,
	input  tagT    i_winTag,
	output resultT o_result,
	output logic   o_resultValid
);

	localparam int K = `CONV_KERNEL;
	localparam sumT CENTER_WEIGHT = sumT'(`CONV_CENTER_WEIGHT);
	localparam sumT EDGE_WEIGHT = sumT'(`CONV_EDGE_WEIGHT);

	pixelT winPix [K][K];

	sumT prod [K][K];
	sumT rowSum [K];
	sumT total;

	logic valid1;
	logic valid2;
	logic valid3;
	tagT  tag1;
	tagT  tag2;
	tagT  tag3;

	// Struct fields as a row by column array
	always_comb begin
		winPix[0][0] = i_window.topLeft;
		winPix[0][1] = i_window.topCenter;
		winPix[0][2] = i_window.topRight;
		winPix[1][0] = i_window.midLeft;
		winPix[1][1] = i_window.midCenter;
		winPix[1][2] = i_window.midRight;
		winPix[2][0] = i_window.botLeft;
		winPix[2][1] = i_window.botCenter;
		winPix[2][2] = i_window.botRight;
	end

	// Stage 1, weighted products
	for (genvar r = 0; r < K; r++) begin : gProdRow
		for (genvar c = 0; c < K; c++) begin : gProdCol
			localparam sumT WEIGHT = ((r == K / 2) && (c == K / 2)) ? CENTER_WEIGHT : EDGE_WEIGHT;

			always_ff @(posedge clk) begin
				if (i_advance) begin
					// Zero extended pixel times signed weight
					prod[r][c] <= sumT'(winPix[r][c]) * WEIGHT;
				end
			end
		end
	end

	// Stage 2, one sum per window row
	for (genvar r = 0; r < K; r++) begin : gRowSum
		always_ff @(posedge clk) begin
			if (i_advance) begin
				rowSum[r] <= prod[r][0] + prod[r][1] + prod[r][2];
			end
		end
	end

	// Stage 3, final total
	always_ff @(posedge clk) begin
		if (i_advance) begin
			total <= rowSum[0] + rowSum[1] + rowSum[2];
		end
	end

	// Tags follow their data through the stages
	always_ff @(posedge clk) begin
		if (i_advance) begin
			tag1 <= i_winTag;
			tag2 <= tag1;
			tag3 <= tag2;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			valid1 <= 1'b0;
			valid2 <= 1'b0;
			valid3 <= 1'b0;
		end else if (i_advance) begin
			valid1 <= i_winValid;
			valid2 <= valid1;
			valid3 <= valid2;
		end
	end

	// Frozen stages keep the output stable under back-pressure
	assign o_result.sum   = total;
	assign o_result.tag   = tag3;
	assign o_resultValid  = valid3;

endmodule

// ==== verilog/convPkg.sv ====
`include "conv_settings.svh"

package convPkg;

	// Plain vector types
	typedef logic [`CONV_PIXEL_BITS-1:0] pixelT;
	typedef logic [`CONV_ROW_WORD_BITS-1:0] rowWordT;
	typedef logic signed [`CONV_SUM_BITS-1:0] sumT;
	typedef logic [`CONV_COL_BITS-1:0] colIdxT;
	typedef logic [`CONV_ROWIDX_BITS-1:0] rowIdxT;

	// 3x3 neighbourhood, top row first
	typedef struct packed {
		pixelT topLeft;
		pixelT topCenter;
		pixelT topRight;
		pixelT midLeft;
		pixelT midCenter;
		pixelT midRight;
		pixelT botLeft;
		pixelT botCenter;
		pixelT botRight;
	} windowT;

	// Position of a result in the output frame
	typedef struct packed {
		rowIdxT outRow;
		colIdxT outCol;
		logic lastPixel;
	} tagT;

	typedef struct packed {
		sumT sum;
		tagT tag;
	} resultT;

	// Frame sequencer states
	typedef enum logic [2:0] {
		IDLE,
		LOAD,
		SWEEP,
		ALIGN,
		DONE
	} ctrlStateT;

endpackage

// ==== verilog/conv_settings.svh ====
`ifndef CONV_SETTINGS_SVH
`define CONV_SETTINGS_SVH

// Pixel and row geometry
`define CONV_PIXEL_BITS     8
`define CONV_ROW_PIXELS     32
`define CONV_ROW_WORD_BITS  (`CONV_ROW_PIXELS * `CONV_PIXEL_BITS)

// Kernel geometry, valid window positions per row
`define CONV_KERNEL         3
`define CONV_OUT_COLS       30

// Sharpening weights
`define CONV_CENTER_WEIGHT  9
`define CONV_EDGE_WEIGHT    (-1)

// Frame height limit and index widths
`define CONV_MAX_HEIGHT     1023
`define CONV_SUM_BITS       16
`define CONV_COL_BITS       5
`define CONV_ROWIDX_BITS    10

`endif

// ==== verilog/frameControl.sv ====
`timescale 1ns/10ps
`include "conv_settings.svh"

module frameControl import convPkg::*; (
	input  logic   clk,
	input  logic   reset,
	input  logic   i_start,
	input  rowIdxT i_height,
	input  logic   i_rowValid,
	output logic   o_rowReady,
	input  logic   i_advance,
	output logic   o_rowPush,
	output logic   o_colRotate,
	output logic   o_winValid,
	output tagT    o_winTag,
	output logic   o_busy
);

	ctrlStateT state;
	rowIdxT    frameHeight;
	rowIdxT    loadCnt;
	rowIdxT    outRow;
	colIdxT    colCnt;
	colIdxT    alignCnt;

	logic startOk;
	logic lastCol;
	logic lastAlign;
	logic lastRow;

	// Start only honoured between frames
	assign startOk = i_start && ((state == IDLE) || (state == DONE));

	assign lastCol   = (colCnt == colIdxT'(`CONV_OUT_COLS - 1));
	assign lastAlign = (alignCnt == colIdxT'(`CONV_ROW_PIXELS - `CONV_OUT_COLS - 1));
	// Final output row is height minus kernel size
	assign lastRow   = (outRow == (frameHeight - rowIdxT'(`CONV_KERNEL)));

	always_ff @(posedge clk) begin
		if (reset) begin
			state       <= IDLE;
			frameHeight <= '0;
			loadCnt     <= '0;
			outRow      <= '0;
			colCnt      <= '0;
			alignCnt    <= '0;
		end else begin
			case (state)
				IDLE, DONE: begin
					if (startOk) begin
						frameHeight <= i_height;
						loadCnt     <= '0;
						outRow      <= '0;
						colCnt      <= '0;
						alignCnt    <= '0;
						state       <= LOAD;
					end
				end
				LOAD: begin
					if (i_rowValid) begin
						loadCnt <= loadCnt + rowIdxT'(1);
						// This row completes the window
						if (loadCnt >= rowIdxT'(`CONV_KERNEL - 1)) begin
							state <= SWEEP;
						end
					end
				end
				SWEEP: begin
					if (i_advance) begin
						if (lastCol) begin
							colCnt <= '0;
							state  <= ALIGN;
						end else begin
							colCnt <= colCnt + colIdxT'(1);
						end
					end
				end
				ALIGN: begin
					// Remaining rotations bring pixel 0 back to the window
					if (i_advance) begin
						if (lastAlign) begin
							alignCnt <= '0;
							if (lastRow) begin
								state <= DONE;
							end else begin
								outRow <= outRow + rowIdxT'(1);
								state  <= LOAD;
							end
						end else begin
							alignCnt <= alignCnt + colIdxT'(1);
						end
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	assign o_rowReady = (state == LOAD);
	assign o_rowPush  = o_rowReady && i_rowValid;

	// One window per advancing cycle, every shift moves one pixel
	assign o_winValid  = (state == SWEEP);
	assign o_colRotate = ((state == SWEEP) || (state == ALIGN)) && i_advance;

	assign o_winTag.outRow    = outRow;
	assign o_winTag.outCol    = colCnt;
	assign o_winTag.lastPixel = (state == SWEEP) && lastCol && lastRow;

	assign o_busy = (state == LOAD) || (state == SWEEP) || (state == ALIGN);

endmodule

// ==== verilog/rowWindowBuffer.sv ====
`timescale 1ns/10ps
`include "conv_settings.svh"

module rowWindowBuffer import convPkg::*; (
	input  logic    clk,
	input  logic    reset,
	input  rowWordT i_rowData,
	input  logic    i_rowPush,
	input  logic    i_colRotate,
	output windowT  o_window
);

	localparam int PIX = `CONV_PIXEL_BITS;
	localparam int ROW_BITS = `CONV_ROW_WORD_BITS;
	localparam int ROWS = `CONV_KERNEL;

	// Index 0 is the oldest row, the top of the window
	rowWordT rows [ROWS];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int r = 0; r < ROWS; r++) begin
				rows[r] <= '0;
			end
		end else if (i_rowPush) begin
			// Rows move up, new row enters at the bottom
			for (int r = 0; r < ROWS - 1; r++) begin
				rows[r] <= rows[r + 1];
			end
			rows[ROWS - 1] <= i_rowData;
		end else if (i_colRotate) begin
			// Pixel k moves to k-1, pixel 0 wraps to the top end
			for (int r = 0; r < ROWS; r++) begin
				rows[r] <= {rows[r][PIX-1:0], rows[r][ROW_BITS-1:PIX]};
			end
		end
	end

	// Window taken from the three lowest pixels of each row
	assign o_window.topLeft   = rows[0][0*PIX +: PIX];
	assign o_window.topCenter = rows[0][1*PIX +: PIX];
	assign o_window.topRight  = rows[0][2*PIX +: PIX];
	assign o_window.midLeft   = rows[1][0*PIX +: PIX];
	assign o_window.midCenter = rows[1][1*PIX +: PIX];
	assign o_window.midRight  = rows[1][2*PIX +: PIX];
	assign o_window.botLeft   = rows[2][0*PIX +: PIX];
	assign o_window.botCenter = rows[2][1*PIX +: PIX];
	assign o_window.botRight  = rows[2][2*PIX +: PIX];

endmodule
